// ==== common/roce_icrc_pkg.sv ====
`default_nettype none

package roce_icrc_pkg;

  // datapath geometry
  localparam int DATA_BYTES = 8;
  localparam int DATA_W     = DATA_BYTES * 8;

  // icrc geometry and crc-32 constants
  localparam int CRC_W      = 32;
  localparam int ICRC_BYTES = 4;

  localparam logic [CRC_W-1:0] CRC_INIT      = 32'hFFFF_FFFF;
  localparam logic [CRC_W-1:0] CRC_POLY_REFL = 32'hEDB8_8320;

  // one stream beat
  // keep is contiguous from lane 0
  typedef struct packed {
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTES-1:0] keep;
    logic                  last;
    logic                  bad;
    logic                  roce;
  } beat_t;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_PAYLOAD = 2'd1,
    ST_TAIL    = 2'd2
  } insert_state_t;

endpackage

`default_nettype wire

// ==== crc/icrc_crc_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module icrc_crc_engine (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire roce_icrc_pkg::beat_t         in_beat,
  input  wire logic                         accept,
  output logic [roce_icrc_pkg::CRC_W-1:0]   icrc
);

  import roce_icrc_pkg::*;

  logic [CRC_W-1:0] crc_reg;
  logic [CRC_W-1:0] crc_next;

  // reflected crc-32, byte by byte in lane order
  always_comb begin
    crc_next = crc_reg;
    for (int i = 0; i < DATA_BYTES; i++) begin
      if (in_beat.keep[i]) begin
        crc_next = crc_next ^ {{(CRC_W-8){1'b0}}, in_beat.data[8*i +: 8]};
        for (int b = 0; b < 8; b++) begin
          if (crc_next[0]) begin
            crc_next = (crc_next >> 1) ^ CRC_POLY_REFL;
          end else begin
            crc_next = crc_next >> 1;
          end
        end
      end
    end
  end

  // valid while the last beat is on the input
  assign icrc = ~crc_next;

  // restart after each frame
  always_ff @(posedge clk) begin
    if (rst) begin
      crc_reg <= CRC_INIT;
    end else if (accept) begin
      if (in_beat.last) begin
        crc_reg <= CRC_INIT;
      end else begin
        crc_reg <= crc_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/axis_skid_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire roce_icrc_pkg::beat_t  in_beat,
  input  wire logic                  in_valid,
  output logic                       ready_early,
  output roce_icrc_pkg::beat_t       out_beat,
  output logic                       out_valid,
  input  wire logic                  out_ready
);

  import roce_icrc_pkg::*;

  beat_t out_reg;
  beat_t tmp_reg;
  logic  out_valid_reg;
  logic  out_valid_next;
  logic  tmp_valid_reg;
  logic  tmp_valid_next;
  logic  ready_q;

  logic  store_in_to_out;
  logic  store_in_to_tmp;
  logic  store_tmp_to_out;

  assign out_beat  = out_reg;
  assign out_valid = out_valid_reg;

  // room next cycle if the sink takes a beat or both stages are empty
  assign ready_early = out_ready | (~tmp_valid_reg & ~out_valid_reg);

  always_comb begin
    out_valid_next   = out_valid_reg;
    tmp_valid_next   = tmp_valid_reg;
    store_in_to_out  = 1'b0;
    store_in_to_tmp  = 1'b0;
    store_tmp_to_out = 1'b0;

    if (ready_q) begin
      if (out_ready || !out_valid_reg) begin
        out_valid_next  = in_valid;
        store_in_to_out = 1'b1;
      end else begin
        tmp_valid_next  = in_valid;
        store_in_to_tmp = 1'b1;
      end
    end else if (out_ready) begin
      // drain temp into output
      out_valid_next   = tmp_valid_reg;
      tmp_valid_next   = 1'b0;
      store_tmp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_reg <= 1'b0;
      tmp_valid_reg <= 1'b0;
      ready_q       <= 1'b0;
    end else begin
      out_valid_reg <= out_valid_next;
      tmp_valid_reg <= tmp_valid_next;
      ready_q       <= ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (store_in_to_out) begin
      out_reg <= in_beat;
    end else if (store_tmp_to_out) begin
      out_reg <= tmp_reg;
    end
    if (store_in_to_tmp) begin
      tmp_reg <= in_beat;
    end
  end

endmodule

`default_nettype wire

// ==== logic/icrc_insert_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module icrc_insert_fsm (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire roce_icrc_pkg::beat_t  in_beat,
  input  wire logic                  s_valid,
  input  wire roce_icrc_pkg::beat_t  merged_beat,
  input  wire roce_icrc_pkg::beat_t  spill_beat,
  input  wire logic                  ready_early,
  output logic                       s_ready,
  output logic                       accept,
  output logic                       out_valid,
  output logic                       busy,
  output roce_icrc_pkg::beat_t       out_beat
);

  import roce_icrc_pkg::*;

  insert_state_t state_reg;
  insert_state_t state_next;

  logic  s_ready_reg;
  logic  s_ready_next;
  logic  ready_q;
  logic  busy_reg;
  logic  hold_spill;
  beat_t spill_reg;

  assign s_ready = s_ready_reg;
  assign accept  = s_valid & s_ready_reg;
  assign busy    = busy_reg;

  always_comb begin
    state_next   = state_reg;
    s_ready_next = 1'b0;
    hold_spill   = 1'b0;
    out_beat     = in_beat;
    out_valid    = 1'b0;

    case (state_reg)
      ST_TAIL: begin
        out_beat  = spill_reg;
        out_valid = 1'b1;
        // skid takes the spill beat this cycle
        if (ready_q) begin
          s_ready_next = ready_early;
          state_next   = ST_IDLE;
        end
      end
      default: begin
        s_ready_next  = ready_early;
        out_valid     = accept;
        out_beat.roce = 1'b0;
        out_beat.bad  = in_beat.last & in_beat.bad;

        if (accept) begin
          if (!in_beat.last) begin
            state_next = ST_PAYLOAD;
          end else begin
            state_next = ST_IDLE;
            // malformed wins over roce
            if (!in_beat.bad && in_beat.roce) begin
              out_beat = merged_beat;
              if (|spill_beat.keep) begin
                hold_spill   = 1'b1;
                s_ready_next = 1'b0;
                state_next   = ST_TAIL;
              end
            end
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_reg   <= ST_IDLE;
      s_ready_reg <= 1'b0;
      ready_q     <= 1'b0;
      busy_reg    <= 1'b0;
    end else begin
      state_reg   <= state_next;
      s_ready_reg <= s_ready_next;
      // same sample the skid stage takes of its early ready
      ready_q     <= ready_early;
      busy_reg    <= (state_next != ST_IDLE);
    end
  end

  always_ff @(posedge clk) begin
    if (hold_spill) begin
      spill_reg <= spill_beat;
    end
  end

endmodule

`default_nettype wire

// ==== logic/icrc_tail_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module icrc_tail_merge (
  input  wire roce_icrc_pkg::beat_t             in_beat,
  input  wire logic [roce_icrc_pkg::CRC_W-1:0]  icrc,
  output roce_icrc_pkg::beat_t                  merged_beat,
  output roce_icrc_pkg::beat_t                  spill_beat
);

  import roce_icrc_pkg::*;

  int unsigned valid_cnt;

  // number of valid lanes in the beat
  always_comb begin
    valid_cnt = 0;
    for (int i = 0; i < DATA_BYTES; i++) begin
      if (in_beat.keep[i]) begin
        valid_cnt = valid_cnt + 1;
      end
    end
  end

  always_comb begin
    int unsigned pos;

    pos = 0;
    merged_beat      = in_beat;
    merged_beat.bad  = 1'b0;
    merged_beat.roce = 1'b0;
    spill_beat       = '0;

    // icrc goes lsb first right after the payload
    for (int j = 0; j < ICRC_BYTES; j++) begin
      pos = valid_cnt + j;
      if (pos < DATA_BYTES) begin
        merged_beat.data[8*pos +: 8] = icrc[8*j +: 8];
        merged_beat.keep[pos]        = 1'b1;
      end else begin
        // wraps into the overflow beat
        spill_beat.data[8*(pos-DATA_BYTES) +: 8] = icrc[8*j +: 8];
        spill_beat.keep[pos-DATA_BYTES]          = 1'b1;
      end
    end

    spill_beat.last  = |spill_beat.keep;
    merged_beat.last = in_beat.last & ~spill_beat.last;
  end

endmodule

`default_nettype wire

// ==== logic/roce_icrc_insert.sv ====
`timescale 1ns/1ps
`default_nettype none

module roce_icrc_insert (
  input  wire logic                                 clk,
  input  wire logic                                 rst,

  input  wire logic [roce_icrc_pkg::DATA_W-1:0]     s_data,
  input  wire logic [roce_icrc_pkg::DATA_BYTES-1:0] s_keep,
  input  wire logic                                 s_last,
  input  wire logic [1:0]                           s_user,
  input  wire logic                                 s_valid,
  output logic                                      s_ready,

  output logic [roce_icrc_pkg::DATA_W-1:0]          m_data,
  output logic [roce_icrc_pkg::DATA_BYTES-1:0]      m_keep,
  output logic                                      m_last,
  output logic                                      m_user,
  output logic                                      m_valid,
  input  wire logic                                 m_ready,

  output logic                                      busy
);

  import roce_icrc_pkg::*;

  beat_t            in_beat;
  beat_t            merged_beat;
  beat_t            spill_beat;
  beat_t            out_beat;
  beat_t            m_beat;
  logic             accept;
  logic             out_valid;
  logic             ready_early;
  logic [CRC_W-1:0] icrc;

  // user bit 0 is malformed, bit 1 is roce
  assign in_beat = '{data: s_data, keep: s_keep, last: s_last, bad: s_user[0], roce: s_user[1]};

  assign m_data = m_beat.data;
  assign m_keep = m_beat.keep;
  assign m_last = m_beat.last;
  assign m_user = m_beat.bad;

  icrc_crc_engine i_icrc_crc_engine (
    .clk     (clk),
    .rst     (rst),
    .in_beat (in_beat),
    .accept  (accept),
    .icrc    (icrc)
  );

  icrc_tail_merge i_icrc_tail_merge (
    .in_beat     (in_beat),
    .icrc        (icrc),
    .merged_beat (merged_beat),
    .spill_beat  (spill_beat)
  );

  icrc_insert_fsm i_icrc_insert_fsm (
    .clk         (clk),
    .rst         (rst),
    .in_beat     (in_beat),
    .s_valid     (s_valid),
    .merged_beat (merged_beat),
    .spill_beat  (spill_beat),
    .ready_early (ready_early),
    .s_ready     (s_ready),
    .accept      (accept),
    .out_valid   (out_valid),
    .busy        (busy),
    .out_beat    (out_beat)
  );

  axis_skid_buffer i_axis_skid_buffer (
    .clk         (clk),
    .rst         (rst),
    .in_beat     (out_beat),
    .in_valid    (out_valid),
    .ready_early (ready_early),
    .out_beat    (m_beat),
    .out_valid   (m_valid),
    .out_ready   (m_ready)
  );

endmodule

`default_nettype wire

// ==== sim/tb_roce_icrc_insert.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_roce_icrc_insert;

  import roce_icrc_pkg::*;

  localparam int SEED       = 50204;
  localparam int NUM_RANDOM = 40;
  localparam int NUM_FRAMES = 1 + 16 + 2 + NUM_RANDOM;

  logic                  clk;
  logic                  rst;
  logic [DATA_W-1:0]     s_data;
  logic [DATA_BYTES-1:0] s_keep;
  logic                  s_last;
  logic [1:0]            s_user;
  logic                  s_valid;
  logic                  s_ready;
  logic [DATA_W-1:0]     m_data;
  logic [DATA_BYTES-1:0] m_keep;
  logic                  m_last;
  logic                  m_user;
  logic                  m_valid;
  logic                  m_ready;
  logic                  busy;

  logic        bp_on;
  logic [31:0] frame_rng;
  logic [31:0] ready_rng;
  logic [7:0]  frame_buf [0:63];

  // expected bytes plus one length and tuser per frame
  logic [7:0] exp_bytes [$];
  int         exp_len [$];
  logic       exp_user [$];
  logic [7:0] got_bytes [$];

  int frames_seen;
  int data_errors;
  int proto_errors;
  int other_failures;

  roce_icrc_insert i_roce_icrc_insert (
    .clk     (clk),
    .rst     (rst),
    .s_data  (s_data),
    .s_keep  (s_keep),
    .s_last  (s_last),
    .s_user  (s_user),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_data  (m_data),
    .m_keep  (m_keep),
    .m_last  (m_last),
    .m_user  (m_user),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .busy    (busy)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] s);
    next_random = s * 32'd1664525 + 32'd1013904223;
  endfunction

  // bit-serial reflected crc-32 over frame_buf
  function automatic logic [31:0] ref_icrc(input int len);
    logic [31:0] crc;
    logic        fb;
    crc = 32'hffff_ffff;
    for (int i = 0; i < len; i++) begin
      for (int k = 0; k < 8; k++) begin
        fb  = crc[0] ^ frame_buf[i][k];
        crc = crc >> 1;
        if (fb) begin
          crc = crc ^ 32'hedb8_8320;
        end
      end
    end
    ref_icrc = ~crc;
  endfunction

  // called right after a rising edge
  task automatic send_frame(input int len, input logic bad, input logic roce);
    int                    pos;
    int                    lane;
    logic [31:0]           crc;
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTES-1:0] keep;
    for (int i = 0; i < len; i++) begin
      frame_rng    = next_random(frame_rng);
      frame_buf[i] = frame_rng[23:16];
      exp_bytes.push_back(frame_buf[i]);
    end
    crc = ref_icrc(len);
    if (roce && !bad) begin
      for (int k = 0; k < 4; k++) begin
        exp_bytes.push_back(crc[8*k +: 8]);
      end
      exp_len.push_back(len + 4);
    end else begin
      exp_len.push_back(len);
    end
    exp_user.push_back(bad);

    pos = 0;
    while (pos < len) begin
      data = '0;
      keep = '0;
      for (lane = 0; lane < DATA_BYTES && pos < len; lane++) begin
        data[8*lane +: 8] = frame_buf[pos];
        keep[lane]        = 1'b1;
        pos++;
      end
      s_valid <= 1'b1;
      s_data  <= data;
      s_keep  <= keep;
      s_last  <= (pos == len);
      s_user  <= (pos == len) ? {roce, bad} : 2'b00;
      // ready is registered, so it is settled at the falling edge
      @(negedge clk);
      // an earlier beat of this frame was already taken
      if (pos > DATA_BYTES && busy !== 1'b1) begin
        $display("ERROR at %0t: busy low in the middle of a frame", $time);
        proto_errors++;
      end
      while (!s_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
    end
  endtask

  task automatic idle_cycles(input int n);
    s_valid <= 1'b0;
    s_last  <= 1'b0;
    s_user  <= 2'b00;
    repeat (n) @(posedge clk);
  endtask

  task automatic compare_frame(input logic user);
    int         exp_n;
    logic       exp_u;
    logic [7:0] exp_b;
    if (exp_len.size() == 0) begin
      $display("ERROR at %0t: output frame with no matching input frame", $time);
      data_errors++;
    end else begin
      exp_n = exp_len.pop_front();
      exp_u = exp_user.pop_front();
      if (got_bytes.size() != exp_n) begin
        $display("ERROR at %0t: frame %0d has %0d bytes, expected %0d",
                 $time, frames_seen, got_bytes.size(), exp_n);
        data_errors++;
      end
      for (int i = 0; i < exp_n; i++) begin
        exp_b = exp_bytes.pop_front();
        if (i < got_bytes.size()) begin
          if (got_bytes[i] !== exp_b) begin
            $display("ERROR at %0t: frame %0d byte %0d is %h, expected %h",
                     $time, frames_seen, i, got_bytes[i], exp_b);
            data_errors++;
          end
        end
      end
      if (user !== exp_u) begin
        $display("ERROR at %0t: frame %0d tuser %b, expected %b", $time, frames_seen, user, exp_u);
        data_errors++;
      end
      frames_seen++;
    end
    got_bytes.delete();
  endtask

  task automatic finish_run;
    $display("frames checked %0d, data errors %0d, protocol errors %0d, other failures %0d",
             frames_seen, data_errors, proto_errors, other_failures);
    if (data_errors + proto_errors + other_failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // sink ready is random only under back-pressure
  always @(posedge clk) begin
    if (bp_on) begin
      ready_rng = next_random(ready_rng);
      m_ready <= (ready_rng[18:16] > 3'd2);
    end else begin
      m_ready <= 1'b1;
    end
  end

  // a beat seen here transfers on the next rising edge
  always @(negedge clk) begin
    if (!rst && m_valid && m_ready) begin
      if (m_keep == '0 || (m_keep & (m_keep + 8'd1)) != '0) begin
        $display("ERROR at %0t: keep %b not contiguous from lane 0", $time, m_keep);
        proto_errors++;
      end
      for (int i = 0; i < DATA_BYTES; i++) begin
        if (m_keep[i]) begin
          got_bytes.push_back(m_data[8*i +: 8]);
        end
      end
      if (m_last) begin
        compare_frame(m_user);
      end else if (m_user) begin
        $display("ERROR at %0t: tuser set on a beat that is not last", $time);
        proto_errors++;
      end
    end
  end

  initial begin
    repeat (NUM_FRAMES * 60) @(posedge clk);
    other_failures++;
    $display("timeout after %0d cycles, %0d expected frames never came out",
             NUM_FRAMES * 60, exp_len.size());
    finish_run();
  end

  initial begin
    int   len;
    logic bad;
    logic roce;
    clk            = 1'b0;
    rst            = 1'b1;
    s_data         = '0;
    s_keep         = '0;
    s_last         = 1'b0;
    s_user         = 2'b00;
    s_valid        = 1'b0;
    m_ready        = 1'b1;
    bp_on          = 1'b0;
    frame_rng      = SEED;
    ready_rng      = next_random(SEED ^ 32'hffff_ffff);
    frames_seen    = 0;
    data_errors    = 0;
    proto_errors   = 0;
    other_failures = 0;

    @(posedge clk);
    @(negedge clk);
    if (m_valid !== 1'b0 || busy !== 1'b0 || s_ready !== 1'b0) begin
      $display("ERROR at %0t: outputs not low in reset (m_valid %b busy %b s_ready %b)",
               $time, m_valid, busy, s_ready);
      proto_errors++;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    send_frame(13, 1'b0, 1'b0);
    idle_cycles(2);
    // every length residue with and without spill
    for (int n = 1; n <= 16; n++) begin
      send_frame(n, 1'b0, 1'b1);
    end
    idle_cycles(2);
    send_frame(21, 1'b1, 1'b1);
    send_frame(11, 1'b0, 1'b1);
    idle_cycles(4);

    bp_on <= 1'b1;
    for (int f = 0; f < NUM_RANDOM; f++) begin
      frame_rng = next_random(frame_rng);
      len       = (frame_rng[25:16] % 40) + 1;
      bad       = (frame_rng[28:27] == 2'b00);
      roce      = frame_rng[30];
      send_frame(len, bad, roce);
    end
    idle_cycles(1);

    while (exp_len.size() != 0) begin
      @(negedge clk);
    end
    idle_cycles(10);
    if (busy !== 1'b0) begin
      $display("ERROR at %0t: busy still high after the last frame", $time);
      proto_errors++;
    end
    if (got_bytes.size() != 0) begin
      $display("output ended with %0d bytes of a frame that never got its last beat",
               got_bytes.size());
      other_failures++;
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== sources.f ====
common/roce_icrc_pkg.sv
crc/icrc_crc_engine.sv
logic/icrc_tail_merge.sv
logic/icrc_insert_fsm.sv
logic/axis_skid_buffer.sv
logic/roce_icrc_insert.sv
sim/tb_roce_icrc_insert.sv
